// File: verilog.f
+incdir+.
ltx_pkg.sv
ltx_link_fsm.sv
ltx_frame_timer.sv
ltx_crc_compute.sv
ltx_packet_gen.sv
ltx_tx_checker.sv
ltx_top.sv
ltx_tb_clk.sv
ltx_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ltx_tb
FILELIST := verilog.f
PASS     := No errors

.PHONY: sim clean

# The run passes only when the testbench prints the pass message on a line of its own
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

// File: ltx_input.txt
// enable rx_rdy cycles valid_pattern data_offset, all hex, one test phase per line
// Valid in phase cycle i is bit (i mod 8) of the pattern, the offset is added to each word
0 0 00000028 000000FF 00000000
1 0 0000003C 000000FF 00000000
1 1 0000003C 000000FF 00000000
1 1 0000005A 000000B5 00001000
1 1 0000003C 0000006C 00000000
1 1 00000028 00000000 00000000
1 0 0000003C 000000FF 00000000
1 1 00000046 00000093 0000A5A5
0 1 00000014 000000FF 00000000
1 1 00000050 000000E7 00000000
1 1 0000003A 000000FF 12340000
1 1 00000020 0000004A 00000000
0 0 0000000A 00000000 00000000
1 1 00000064 000000D9 00000077
1 0 0000001D 0000005F 00000000
1 1 0000004B 000000A6 00000000
0 0 00000008 000000FF 00000000
F 0 00000000 00000000 00000000

// File: ltx_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the TX framer that replays phases from the input data file
// A cycle model of the link predicts ready and every output word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ltx_params.svh"

module ltx_tb;
   import ltx_pkg::*;

   localparam int FRAME_LEN   = 1 + `LTX_FAW_BLOCKS * (`LTX_SLOTS + 1);
   localparam int FAW_TIMEOUT = 2 * FRAME_LEN + `LTX_PIPE_DEPTH + 8;
   localparam int MAX_ROWS    = 256;

   logic        clk;
   logic        rst_n;
   logic        enable;
   logic        rx_rdy;
   logic [63:0] tdata;
   logic        tvalid;
   logic        tready;
   logic [63:0] m_tdata;

   // Each phase takes five words for enable, rx_rdy, cycles, valid pattern and data offset
   logic [31:0] stim_mem [0:MAX_ROWS-1];

   ltx_state_e            st;
   int                    cyc;
   logic [`LTX_SLOTS-1:0] vmask;
   logic [15:0]           pair_acc;
   logic [15:0]           pair_crc [0:2];
   logic [63:0]           exp_q [$];
   int                    chk_cnt;
   int                    err_cnt;

   ltx_tb_clk u_clk (
      .clk_o (clk)
   );

   ltx_top UUT (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .enable_i        (enable),
      .rx_rdy_i        (rx_rdy),
      .s_axis_tdata_i  (tdata),
      .s_axis_tvalid_i (tvalid),
      .s_axis_tready_o (tready),
      .m_axis_tdata_o  (m_tdata)
   );

   // CRC-16 of one slot word taken MSB first and continued from start
   function automatic logic [15:0] crc16_over_word(input logic [15:0] start,
                                                   input logic [63:0] data);
      logic [15:0] r;
      logic        fb;
      r = start;
      for (int b = 63; b >= 0; b--) begin
         fb = r[15] ^ data[b];
         r  = {r[14:0], 1'b0};
         if (fb) begin
            r = r ^ `LTX_CRC16_POLY;
         end
      end
      return r;
   endfunction

   // CRC-8 over the valid bits with the highest slot first
   function automatic logic [7:0] crc8_over_valids(input logic [`LTX_SLOTS-1:0] v);
      logic [7:0] r;
      logic       fb;
      r = `LTX_CRC8_INIT;
      for (int b = `LTX_SLOTS - 1; b >= 0; b--) begin
         fb = r[7] ^ v[b];
         r  = {r[6:0], 1'b0};
         if (fb) begin
            r = r ^ `LTX_CRC8_POLY;
         end
      end
      return r;
   endfunction

   task automatic check_value(input string what, input logic [63:0] actual,
                              input logic [63:0] expected);
      chk_cnt++;
      if (actual !== expected) begin
         err_cnt++;
         $display("[ERROR] %0t: %s mismatch, expected %h, got %h",
                  $time, what, expected, actual);
      end
   endtask

   // Called at the falling edge, where inputs and outputs of the cycle are stable
   task automatic step_model();
      int          pos;
      int          k;
      logic        faw;
      logic        crcb;
      logic        rdy;
      logic        acc;
      logic [63:0] word;
      logic [63:0] pick;
      logic [63:0] expected;
      pos  = cyc % FRAME_LEN;
      faw  = (pos == 0);
      k    = faw ? 0 : (pos - 1) % (`LTX_SLOTS + 1);
      crcb = !faw && (k == `LTX_SLOTS);
      rdy  = (st == LTX_ACTIVE) && !faw && !crcb;
      acc  = rdy && tvalid;
      check_value("ready", {63'd0, tready}, {63'd0, rdy});
      expected = exp_q.pop_front();
      check_value("output word", m_tdata, expected);
      if (!faw && !crcb) begin
         word = acc ? tdata : `LTX_IDLE_WORD;
         if (k == 0) begin
            vmask = '0;
         end
         vmask[k[2:0]] = acc;
         if (k[0] == 1'b0) begin
            pair_acc = crc16_over_word(`LTX_CRC16_INIT, word);
         end else begin
            pair_acc = crc16_over_word(pair_acc, word);
         end
         pair_crc[k[2:1]] = pair_acc;
      end
      if (st == LTX_OFF) begin
         pick = `LTX_IDLE_WORD;
      end else if (faw) begin
         pick = `LTX_FAW_WORD;
      end else if (crcb) begin
         pick = {2'b00,
                 (st == LTX_IDLE) ? {`LTX_SLOTS{1'b0}} : vmask,
                 crc8_over_valids(vmask),
                 pair_crc[2], pair_crc[1], pair_crc[0]};
      end else if (acc) begin
         pick = tdata;
      end else begin
         pick = `LTX_IDLE_WORD;
      end
      exp_q.push_back(pick);
      // State for the next cycle
      if (!enable) begin
         st = LTX_OFF;
      end else if (faw) begin
         if (st == LTX_OFF) begin
            st = LTX_IDLE;
         end else begin
            st = rx_rdy ? LTX_ACTIVE : LTX_IDLE;
         end
      end
      cyc++;
   endtask

   task automatic drive_cycle(input logic en, input logic rx, input logic vld,
                              input logic [63:0] data);
      @(posedge clk);
      enable <= en;
      rx_rdy <= rx;
      tvalid <= vld;
      tdata  <= data;
      @(negedge clk);
      step_model();
   endtask

   task automatic wait_for_faw(input logic en, input logic rx, output logic found);
      int n;
      found = 1'b0;
      n     = 0;
      while (!found && n < FAW_TIMEOUT) begin
         drive_cycle(en, rx, 1'b0, {$urandom(), $urandom()});
         found = is_faw(m_tdata);
         n++;
      end
   endtask

   initial begin
      int          ph;
      int          cycles;
      int          errs_before;
      logic [7:0]  base;
      logic [7:0]  pat;
      logic [31:0] ofs;
      logic        en;
      logic        rx;
      logic        found;
      logic        aborted;
      rst_n      = 1'b0;
      enable     = 1'b0;
      rx_rdy     = 1'b0;
      tvalid     = 1'b0;
      tdata      = '0;
      chk_cnt    = 0;
      err_cnt    = 0;
      void'($urandom(32'hf63b));
      $readmemh("ltx_input.txt", stim_mem);
      st    = LTX_OFF;
      cyc   = 0;
      vmask = '0;
      for (int i = 0; i < `LTX_PIPE_DEPTH; i++) begin
         exp_q.push_back(`LTX_IDLE_WORD);
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      step_model();
      ph      = 0;
      aborted = 1'b0;
      base    = 8'd0;
      while (ph < MAX_ROWS / 5 && stim_mem[base] <= 32'd1 && !aborted) begin
         en          = stim_mem[base][0];
         rx          = stim_mem[base + 8'd1][0];
         cycles      = int'(stim_mem[base + 8'd2]);
         pat         = stim_mem[base + 8'd3][7:0];
         ofs         = stim_mem[base + 8'd4];
         errs_before = err_cnt;
         for (int i = 0; i < cycles; i++) begin
            drive_cycle(en, rx, pat[i[2:0]], {$urandom(), $urandom()} + 64'(ofs));
         end
         // An enabled link must show the FAW word within two superframes
         if (en) begin
            wait_for_faw(en, rx, found);
            if (!found) begin
               $display("Timeout: no FAW word on the output in test %0d", ph + 1);
               err_cnt++;
               aborted = 1'b1;
            end
         end
         if (err_cnt == errs_before) begin
            $display("Test %0d: enable %0d rx_rdy %0d, %0d cycles, ok",
                     ph + 1, en, rx, cycles);
         end else begin
            $display("Test %0d: enable %0d rx_rdy %0d, %0d cycles, %0d mismatches",
                     ph + 1, en, rx, cycles, err_cnt - errs_before);
         end
         ph++;
         base = 8'(5 * ph);
      end
      $display("Tests: %0d, checks: %0d, errors: %0d", ph, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: ltx_tb_clk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running 10 ns clock for the TX framer testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ltx_tb_clk (
   output logic clk_o
);
   initial clk_o = 1'b0;

   always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: ltx_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TX framer top level joining FSM, timer, CRC and packet path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ltx_top (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        enable_i,
   input  logic        rx_rdy_i,
   input  logic [63:0] s_axis_tdata_i,
   input  logic        s_axis_tvalid_i,
   output logic        s_axis_tready_o,
   output logic [63:0] m_axis_tdata_o
);
   import ltx_pkg::*;

   ltx_state_e  state;
   ltx_bound_t  bound;
   ltx_crc_t    crc;
   logic        crc_valid;
   logic        slot_vld;
   logic [63:0] slot_data;

   ltx_link_fsm u_fsm (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .enable_i (enable_i),
      .rx_rdy_i (rx_rdy_i),
      .bound_i  (bound),
      .state_o  (state)
   );

   ltx_frame_timer u_timer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bound_o (bound)
   );

   ltx_crc_compute u_crc (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .bound_i     (bound),
      .slot_vld_i  (slot_vld),
      .slot_data_i (slot_data),
      .crc_o       (crc),
      .crc_valid_o (crc_valid)
   );

   ltx_packet_gen u_pkt (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .state_i         (state),
      .bound_i         (bound),
      .s_axis_tdata_i  (s_axis_tdata_i),
      .s_axis_tvalid_i (s_axis_tvalid_i),
      .s_axis_tready_o (s_axis_tready_o),
      .crc_i           (crc),
      .crc_valid_i     (crc_valid),
      .slot_vld_o      (slot_vld),
      .slot_data_o     (slot_data),
      .m_axis_tdata_o  (m_axis_tdata_o)
   );

   ltx_tx_checker u_chk (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .state_i         (state),
      .bound_i         (bound),
      .s_axis_tdata_i  (s_axis_tdata_i),
      .s_axis_tvalid_i (s_axis_tvalid_i),
      .s_axis_tready_i (s_axis_tready_o),
      .m_axis_tdata_i  (m_axis_tdata_o),
      .crc_i           (crc),
      .crc_valid_i     (crc_valid)
   );

endmodule

`default_nettype wire

// File: ltx_tx_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Framer-wide properties and cover points
// Observes the top-level ports and the internal FSM, timer and CRC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ltx_params.svh"

module ltx_tx_checker (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  ltx_pkg::ltx_state_e   state_i,
   input  ltx_pkg::ltx_bound_t   bound_i,
   input  logic [63:0]           s_axis_tdata_i,
   input  logic                  s_axis_tvalid_i,
   input  logic                  s_axis_tready_i,
   input  logic [63:0]           m_axis_tdata_i,
   input  ltx_pkg::ltx_crc_t     crc_i,
   input  logic                  crc_valid_i
);
   import ltx_pkg::*;

   ltx_word_u             out_w;
   logic [8:0]            acc_hist_q;
   logic [`LTX_SLOTS-1:0] exp_valids;

   assign out_w.raw = m_axis_tdata_i;

   // Acceptance history; bit j is the transfer j+1 cycles back
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_hist_q <= '0;
      end else begin
         acc_hist_q <= {acc_hist_q[7:0], s_axis_tvalid_i && s_axis_tready_i};
      end
   end

   // Slot k of the block sat 9-k cycles before the packet reaches the output
   always_comb begin
      for (int k = 0; k < `LTX_SLOTS; k++) begin
         exp_valids[k] = acc_hist_q[8-k];
      end
   end

   c_ready : cover property (@(posedge clk_i) s_axis_tready_i);
   c_nonzero_out : cover property (@(posedge clk_i) m_axis_tdata_i != `LTX_IDLE_WORD);

   a_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(s_axis_tvalid_i && s_axis_tready_i, `LTX_PIPE_DEPTH)
      |-> m_axis_tdata_i == $past(s_axis_tdata_i, `LTX_PIPE_DEPTH))
      else $error("Accepted word did not reach the output after the pipeline delay");

   a_off_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(state_i == LTX_OFF, `LTX_PIPE_DEPTH) |-> m_axis_tdata_i == `LTX_IDLE_WORD)
      else $error("Non-idle word sent while the link was off");

   a_idle_boundary_only : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(state_i == LTX_IDLE, `LTX_PIPE_DEPTH) && (m_axis_tdata_i != `LTX_IDLE_WORD)
      |-> $past(bound_i.faw || bound_i.crc, `LTX_PIPE_DEPTH))
      else $error("Non-boundary word sent while the link was idle");

   a_faw_word : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(bound_i.faw && (state_i != LTX_OFF), `LTX_PIPE_DEPTH) |-> is_faw(m_axis_tdata_i))
      else $error("FAW boundary without the FAW pattern");

   a_valid_bits : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(bound_i.crc && (state_i != LTX_OFF), `LTX_PIPE_DEPTH)
      |-> out_w.pkt.valids == exp_valids)
      else $error("Valid bits do not match the accepted slots");

   a_crc_fields : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(bound_i.crc && (state_i != LTX_OFF), `LTX_PIPE_DEPTH)
      |-> $past(crc_valid_i, `LTX_PIPE_DEPTH)
          && ({out_w.pkt.crcvw, out_w.pkt.crc45, out_w.pkt.crc23, out_w.pkt.crc01}
              == $past({crc_i.crcvw, crc_i.crc45, crc_i.crc23, crc_i.crc01},
                       `LTX_PIPE_DEPTH)))
      else $error("CRC fields differ from the CRC unit");

   a_ready_rule : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_axis_tready_i == ((state_i == LTX_ACTIVE) && !bound_i.faw && !bound_i.crc))
      else $error("Ready does not follow active state and boundaries");

endmodule

`default_nettype wire

// File: ltx_packet_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link word multiplexer with a three-stage output pipeline
// Accepts AXI-Stream data on non-boundary cycles when active
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ltx_params.svh"

module ltx_packet_gen (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  ltx_pkg::ltx_state_e   state_i,
   input  ltx_pkg::ltx_bound_t   bound_i,
   input  logic [63:0]           s_axis_tdata_i,
   input  logic                  s_axis_tvalid_i,
   output logic                  s_axis_tready_o,
   input  ltx_pkg::ltx_crc_t     crc_i,
   input  logic                  crc_valid_i,
   output logic                  slot_vld_o,
   output logic [63:0]           slot_data_o,
   output logic [63:0]           m_axis_tdata_o
);
   import ltx_pkg::*;

   logic        accept;
   ltx_word_u   pick;
   logic [63:0] stage1_q;
   logic [63:0] stage2_q;
   logic [63:0] stage3_q;

   // Ready comes from registered state and timer only
   assign s_axis_tready_o = (state_i == LTX_ACTIVE) && !bound_i.faw && !bound_i.crc;
   assign accept          = s_axis_tready_o && s_axis_tvalid_i;

   // An empty slot counts as the idle word for the CRC
   assign slot_vld_o  = accept;
   assign slot_data_o = accept ? s_axis_tdata_i : `LTX_IDLE_WORD;

   always_comb begin
      pick.raw = `LTX_IDLE_WORD;
      if (state_i == LTX_OFF) begin
         pick.raw = `LTX_IDLE_WORD;
      end else if (bound_i.faw) begin
         pick.raw = `LTX_FAW_WORD;
      end else if (bound_i.crc) begin
         pick.pkt.rsvd   = 2'b00;
         // No slot carries data while idle
         pick.pkt.valids = (state_i == LTX_IDLE) ? '0 : crc_i.valids;
         pick.pkt.crcvw  = crc_i.crcvw;
         pick.pkt.crc45  = crc_i.crc45;
         pick.pkt.crc23  = crc_i.crc23;
         pick.pkt.crc01  = crc_i.crc01;
      end else if (accept) begin
         pick.raw = s_axis_tdata_i;
      end
   end

   // The link sees idle words until the first chosen word arrives
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stage1_q <= `LTX_IDLE_WORD;
         stage2_q <= `LTX_IDLE_WORD;
         stage3_q <= `LTX_IDLE_WORD;
      end else begin
         stage1_q <= pick.raw;
         stage2_q <= stage1_q;
         stage3_q <= stage2_q;
      end
   end

   assign m_axis_tdata_o = stage3_q;

   a_crc_ready : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bound_i.crc && (state_i != LTX_OFF) |-> crc_valid_i)
      else $error("CRC boundary reached before the CRC unit finished");

endmodule

`default_nettype wire

// File: ltx_crc_compute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-block CRC unit for the validity/CRC word
// Fed with the slot contents chosen by the packet generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ltx_params.svh"

module ltx_crc_compute (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  ltx_pkg::ltx_bound_t   bound_i,
   input  logic                  slot_vld_i,
   input  logic [63:0]           slot_data_i,
   output ltx_pkg::ltx_crc_t     crc_o,
   output logic                  crc_valid_o
);
   import ltx_pkg::*;

   logic [2:0]            slot_q;
   logic [`LTX_SLOTS-1:0] vld_q;
   logic [`LTX_SLOTS-1:0] vld_nxt;
   logic                  crc_valid_q;
   logic [15:0]           acc_q;
   logic [15:0]           acc_nxt;
   logic                  slot_cyc;
   ltx_crc_t              crc_q;

   // CRC-16 advanced over one 64-bit word, MSB first
   function automatic logic [15:0] crc16_word(input logic [15:0] seed,
                                              input logic [63:0] data);
      logic [15:0] c;
      c = seed;
      for (int i = 63; i >= 0; i--) begin
         c = (c[15] ^ data[i]) ? ({c[14:0], 1'b0} ^ `LTX_CRC16_POLY) : {c[14:0], 1'b0};
      end
      return c;
   endfunction

   function automatic logic [7:0] crc8_valids(input logic [`LTX_SLOTS-1:0] v);
      logic [7:0] c;
      c = `LTX_CRC8_INIT;
      for (int i = `LTX_SLOTS - 1; i >= 0; i--) begin
         c = (c[7] ^ v[i]) ? ({c[6:0], 1'b0} ^ `LTX_CRC8_POLY) : {c[6:0], 1'b0};
      end
      return c;
   endfunction

   assign slot_cyc = !bound_i.faw && !bound_i.crc;
   // Newest slot enters at the top so the oldest ends in bit 0
   assign vld_nxt  = {slot_vld_i, vld_q[`LTX_SLOTS-1:1]};
   // Even slots open a pair with the initial value
   assign acc_nxt  = crc16_word(slot_q[0] ? acc_q : `LTX_CRC16_INIT, slot_data_i);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         slot_q      <= 3'd0;
         vld_q       <= '0;
         crc_valid_q <= 1'b0;
      end else begin
         crc_valid_q <= slot_cyc && (slot_q == 3'(`LTX_SLOTS - 1));
         if (slot_cyc) begin
            slot_q <= slot_q + 3'd1;
            vld_q  <= vld_nxt;
         end else begin
            slot_q <= 3'd0;
            vld_q  <= '0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (slot_cyc) begin
         acc_q <= acc_nxt;
         if (slot_q[0]) begin
            case (slot_q[2:1])
               2'd0:    crc_q.crc01 <= acc_nxt;
               2'd1:    crc_q.crc23 <= acc_nxt;
               default: crc_q.crc45 <= acc_nxt;
            endcase
         end
         if (slot_q == 3'(`LTX_SLOTS - 1)) begin
            crc_q.valids <= vld_nxt;
            crc_q.crcvw  <= crc8_valids(vld_nxt);
         end
      end
   end

   assign crc_o       = crc_q;
   assign crc_valid_o = crc_valid_q;

   // The result is only ever presented on the timer's CRC slot
   a_valid_on_crc : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      crc_valid_o |-> bound_i.crc)
      else $error("CRC result ready outside a CRC boundary");

endmodule

`default_nettype wire

// File: ltx_frame_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Superframe timer marking FAW and CRC boundary cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ltx_params.svh"

module ltx_frame_timer (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   output ltx_pkg::ltx_bound_t   bound_o
);
   import ltx_pkg::*;

   logic       faw_q;
   logic [2:0] slot_q;
   logic [1:0] blk_q;

   // Position LTX_SLOTS within a block is the CRC word
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         faw_q  <= 1'b1;
         slot_q <= 3'd0;
         blk_q  <= 2'd0;
      end else if (faw_q) begin
         faw_q <= 1'b0;
      end else if (slot_q == 3'(`LTX_SLOTS)) begin
         slot_q <= 3'd0;
         if (blk_q == 2'(`LTX_FAW_BLOCKS - 1)) begin
            blk_q <= 2'd0;
            faw_q <= 1'b1;
         end else begin
            blk_q <= blk_q + 2'd1;
         end
      end else begin
         slot_q <= slot_q + 3'd1;
      end
   end

   assign bound_o.faw = faw_q;
   assign bound_o.crc = (slot_q == 3'(`LTX_SLOTS));

   a_bound_exclusive : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(bound_o.faw && bound_o.crc))
      else $error("FAW and CRC boundaries coincide");

endmodule

`default_nettype wire

// File: ltx_link_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link state machine (off, idle, active) of the TX framer
// Moves only on superframe edges except when disabled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ltx_link_fsm (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   enable_i,
   input  logic                   rx_rdy_i,
   input  ltx_pkg::ltx_bound_t    bound_i,
   output ltx_pkg::ltx_state_e    state_o
);
   import ltx_pkg::*;

   ltx_state_e state_q;
   ltx_state_e state_d;

   always_comb begin
      state_d = state_q;
      if (!enable_i) begin
         state_d = LTX_OFF;
      end else if (bound_i.faw) begin
         // Partner readiness decides between idle and active
         if (state_q == LTX_OFF) begin
            state_d = LTX_IDLE;
         end else begin
            state_d = rx_rdy_i ? LTX_ACTIVE : LTX_IDLE;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= LTX_OFF;
      end else begin
         state_q <= state_d;
      end
   end

   assign state_o = state_q;

   // The link always passes through idle on its way up
   a_no_off_to_active : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      state_q == LTX_OFF |=> state_q != LTX_ACTIVE)
      else $error("Link state jumped from off to active");

endmodule

`default_nettype wire

// File: ltx_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the TX framer and the FAW match helper
// Compile before every module that imports it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "ltx_params.svh"

package ltx_pkg;

   typedef enum logic [1:0] {
      LTX_OFF    = 2'd0,
      LTX_IDLE   = 2'd1,
      LTX_ACTIVE = 2'd2
   } ltx_state_e;

   typedef struct packed {
      logic faw;
      logic crc;
   } ltx_bound_t;

   // Layout of the validity/CRC word as it goes on the link
   typedef struct packed {
      logic [1:0]            rsvd;
      logic [`LTX_SLOTS-1:0] valids;
      logic [7:0]            crcvw;
      logic [15:0]           crc45;
      logic [15:0]           crc23;
      logic [15:0]           crc01;
   } ltx_vd_pkt_t;

   typedef struct packed {
      logic [`LTX_SLOTS-1:0] valids;
      logic [7:0]            crcvw;
      logic [15:0]           crc45;
      logic [15:0]           crc23;
      logic [15:0]           crc01;
   } ltx_crc_t;

   // A link word is either raw slot data or a validity packet
   typedef union packed {
      logic [63:0] raw;
      ltx_vd_pkt_t pkt;
   } ltx_word_u;

   function automatic logic is_faw(input logic [63:0] word);
      return word == `LTX_FAW_WORD;
   endfunction

endpackage

`default_nettype wire

// File: ltx_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame geometry, latency and code constants of the TX framer
// Include wherever a macro below is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LTX_PARAMS_SVH
`define LTX_PARAMS_SVH

`define LTX_SLOTS       6
`define LTX_FAW_BLOCKS  4
`define LTX_PIPE_DEPTH  3
`define LTX_FAW_WORD    64'h7A3C_5E0F_A1C3_96D4
`define LTX_IDLE_WORD   64'h0000_0000_0000_0000
`define LTX_CRC16_POLY  16'h1021
`define LTX_CRC16_INIT  16'hFFFF
`define LTX_CRC8_POLY   8'h07
`define LTX_CRC8_INIT   8'h00

`endif
